// File: logic/cu_params.svh
`ifndef CU_PARAMS_SVH
`define CU_PARAMS_SVH

// instruction word
`define CU_WORD_W 32

// opcode field sits at the top of the word
`define CU_OPCODE_W 5
`define CU_OPCODE_MSB 31
`define CU_OPCODE_LSB 27

// microstep encoding width
`define CU_STATE_W 6

`endif

// File: logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

`include "cu_params.svh"

    // full opcode map, unsupported ones kept so decode can name them
    typedef enum logic [`CU_OPCODE_W-1:0] {
        op_ld   = 5'b00000,
        op_ldi  = 5'b00001,
        op_st   = 5'b00010,
        op_add  = 5'b00011,
        op_sub  = 5'b00100,
        op_shr  = 5'b00101,
        op_shra = 5'b00110,
        op_shl  = 5'b00111,
        op_ror  = 5'b01000,
        op_rol  = 5'b01001,
        op_and  = 5'b01010,
        op_or   = 5'b01011,
        op_addi = 5'b01100,
        op_andi = 5'b01101,
        op_ori  = 5'b01110,
        op_mul  = 5'b01111,  // not supported
        op_div  = 5'b10000,  // not supported
        op_neg  = 5'b10001,
        op_not  = 5'b10010,
        op_br   = 5'b10011,
        op_jr   = 5'b10100,  // not supported
        op_jal  = 5'b10101,  // not supported
        op_in   = 5'b10110,  // not supported
        op_out  = 5'b10111,  // not supported
        op_mfhi = 5'b11000,  // not supported
        op_mflo = 5'b11001,  // not supported
        op_nop  = 5'b11010
    } opcode_e;

endpackage

`default_nettype wire

// File: logic/cu_pkg.sv
`default_nettype none

package cu_pkg;

`include "cu_params.svh"

    typedef enum logic [`CU_STATE_W-1:0] {
        reset_step = 6'd0,
        fetch0,
        fetch1,
        fetch2,
        // load
        ld3,
        ld4,
        ld5,
        ld6,
        ld7,
        // load immediate
        ldi3,
        ldi4,
        ldi5,
        // store
        st3,
        st4,
        st5,
        st6,
        st7,
        // conditional branch
        br3,
        br4,
        br5,
        br6,
        // three-register alu ops, shifts and rotates
        alu3,
        alu4,
        alu5,
        // addi, andi, ori
        imm3,
        imm4,
        imm5,
        // neg, not
        unary3,
        unary4,
        nop3
    } step_e;

    // each microstep spans two clocks
    typedef enum logic {
        first_half  = 1'b0,
        second_half = 1'b1
    } phase_e;

endpackage

`default_nettype wire

// File: logic/ctrl_if.sv
`default_nettype none
`timescale 1ns/100ps

// one cycle's worth of decoded strobes
interface ctrl_if;
    logic read;
    logic ram_write;
    logic con_enable;
    logic pc_enable;
    logic ir_enable;
    logic y_enable;
    logic z_enable;
    logic mar_enable;
    logic mdr_enable;
    logic c_sign_extended_out;
    logic ba_out;
    logic gra;
    logic grb;
    logic grc;
    logic r_in;
    logic r_out;
    logic zlo_out;
    logic mdr_out;
    logic pc_out;
    logic pc_increment;
    logic y_clr;
    logic ir_clr;
    logic hold_clr;  // high during reset_step

    modport source (
        output read, ram_write, con_enable, pc_enable, ir_enable, y_enable, z_enable,
               mar_enable, mdr_enable, c_sign_extended_out, ba_out, gra, grb, grc,
               r_in, r_out, zlo_out, mdr_out, pc_out, pc_increment, y_clr, ir_clr,
               hold_clr
    );

    modport sink (
        input read, ram_write, con_enable, pc_enable, ir_enable, y_enable, z_enable,
              mar_enable, mdr_enable, c_sign_extended_out, ba_out, gra, grb, grc,
              r_in, r_out, zlo_out, mdr_out, pc_out, pc_increment, y_clr, ir_clr,
              hold_clr
    );
endinterface

`default_nettype wire

// File: logic/step_sequencer.sv
`default_nettype none
`timescale 1ns/100ps

`include "cu_params.svh"

module step_sequencer
    import isa_pkg::*, cu_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic [`CU_WORD_W-1:0] ir,
    output step_e                      step,
    output phase_e                     phase
);

    opcode_e opcode;
    step_e   next_step;

    assign opcode = opcode_e'(ir[`CU_OPCODE_MSB:`CU_OPCODE_LSB]);

    // first execute step of each instruction group
    always_comb begin
        case (step)
            reset_step: next_step = fetch0;
            fetch0:     next_step = fetch1;
            fetch1:     next_step = fetch2;
            fetch2: begin
                case (opcode)
                    op_ld:   next_step = ld3;
                    op_ldi:  next_step = ldi3;
                    op_st:   next_step = st3;
                    op_br:   next_step = br3;
                    op_add, op_sub, op_and, op_or,
                    op_shr, op_shra, op_shl, op_ror, op_rol:
                        next_step = alu3;
                    op_addi, op_andi, op_ori:
                        next_step = imm3;
                    op_neg, op_not:
                        next_step = unary3;
                    default: next_step = nop3;  // nop, dropped and undefined codes
                endcase
            end
            ld3:    next_step = ld4;
            ld4:    next_step = ld5;
            ld5:    next_step = ld6;
            ld6:    next_step = ld7;
            ldi3:   next_step = ldi4;
            ldi4:   next_step = ldi5;
            st3:    next_step = st4;
            st4:    next_step = st5;
            st5:    next_step = st6;
            st6:    next_step = st7;
            br3:    next_step = br4;
            br4:    next_step = br5;
            br5:    next_step = br6;
            alu3:   next_step = alu4;
            alu4:   next_step = alu5;
            imm3:   next_step = imm4;
            imm4:   next_step = imm5;
            unary3: next_step = unary4;
            // last step of every group
            ld7, ldi5, st7, br6, alu5, imm5, unary4, nop3:
                next_step = fetch0;
            default: next_step = reset_step;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= first_half;
            step  <= reset_step;
        end else begin
            phase <= (phase == first_half) ? second_half : first_half;
            if (phase == second_half) begin
                step <= next_step;  // advance once per two clocks
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/microstep_decoder.sv
`default_nettype none
`timescale 1ns/100ps

module microstep_decoder
    import cu_pkg::*;
(
    input  wire step_e   step,
    input  wire phase_e  phase,
    input  wire logic    con_ff,
    ctrl_if.source       ctrl
);

    always_comb begin
        ctrl.read                = 1'b0;
        ctrl.ram_write           = 1'b0;
        ctrl.con_enable          = 1'b0;
        ctrl.pc_enable           = 1'b0;
        ctrl.ir_enable           = 1'b0;
        ctrl.y_enable            = 1'b0;
        ctrl.z_enable            = 1'b0;
        ctrl.mar_enable          = 1'b0;
        ctrl.mdr_enable          = 1'b0;
        ctrl.c_sign_extended_out = 1'b0;
        ctrl.ba_out              = 1'b0;
        ctrl.gra                 = 1'b0;
        ctrl.grb                 = 1'b0;
        ctrl.grc                 = 1'b0;
        ctrl.r_in                = 1'b0;
        ctrl.r_out               = 1'b0;
        ctrl.zlo_out             = 1'b0;
        ctrl.mdr_out             = 1'b0;
        ctrl.pc_out              = 1'b0;
        ctrl.pc_increment        = 1'b0;
        ctrl.y_clr               = 1'b0;
        ctrl.ir_clr              = 1'b0;
        ctrl.hold_clr            = (step == reset_step);  // both halves

        if (phase == first_half) begin
            case (step)
                fetch0: begin
                    ctrl.pc_out       = 1'b1;
                    ctrl.mar_enable   = 1'b1;
                    ctrl.pc_increment = 1'b1;
                    ctrl.ir_clr       = 1'b1;
                    ctrl.y_clr        = 1'b1;
                end
                fetch1: begin
                    ctrl.read       = 1'b1;
                    ctrl.mdr_enable = 1'b1;
                    ctrl.pc_enable  = 1'b1;
                    ctrl.zlo_out    = 1'b1;
                end
                fetch2: begin
                    ctrl.mdr_out   = 1'b1;
                    ctrl.ir_enable = 1'b1;
                end
                ld3, ldi3: begin  // base address into y
                    ctrl.grb      = 1'b1;
                    ctrl.ba_out   = 1'b1;
                    ctrl.y_enable = 1'b1;
                end
                st3: begin
                    ctrl.gra      = 1'b1;
                    ctrl.ba_out   = 1'b1;
                    ctrl.y_enable = 1'b1;
                end
                ld4, ldi4, st4, imm4, br5: begin
                    ctrl.c_sign_extended_out = 1'b1;
                    ctrl.z_enable            = 1'b1;
                end
                ld5, st5: begin
                    ctrl.zlo_out    = 1'b1;
                    ctrl.mar_enable = 1'b1;
                end
                ld6: begin
                    ctrl.read       = 1'b1;
                    ctrl.mdr_enable = 1'b1;
                end
                ld7: begin
                    ctrl.mdr_out = 1'b1;
                    ctrl.gra     = 1'b1;
                    ctrl.r_in    = 1'b1;
                end
                ldi5, alu5, imm5, unary4: begin  // write back z
                    ctrl.zlo_out = 1'b1;
                    ctrl.gra     = 1'b1;
                    ctrl.r_in    = 1'b1;
                end
                st6: begin
                    ctrl.grb        = 1'b1;
                    ctrl.r_out      = 1'b1;
                    ctrl.mdr_enable = 1'b1;
                end
                st7: ctrl.ram_write = 1'b1;
                br3: begin
                    ctrl.gra        = 1'b1;
                    ctrl.r_out      = 1'b1;
                    ctrl.con_enable = 1'b1;
                end
                br4: begin
                    ctrl.pc_out   = 1'b1;
                    ctrl.y_enable = 1'b1;
                end
                br6: begin
                    ctrl.zlo_out   = 1'b1;
                    ctrl.pc_enable = con_ff;  // taken branch only
                end
                alu3, imm3: begin
                    ctrl.grb      = 1'b1;
                    ctrl.r_out    = 1'b1;
                    ctrl.y_enable = 1'b1;
                end
                alu4: begin
                    ctrl.grc      = 1'b1;
                    ctrl.r_out    = 1'b1;
                    ctrl.z_enable = 1'b1;
                end
                unary3: begin
                    ctrl.grb      = 1'b1;
                    ctrl.r_out    = 1'b1;
                    ctrl.z_enable = 1'b1;
                end
                default: ;  // reset_step and nop3 raise nothing
            endcase
        end else if (step == fetch0) begin
            // incremented pc latched into z
            ctrl.pc_out   = 1'b1;
            ctrl.z_enable = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/strobe_register.sv
`default_nettype none
`timescale 1ns/100ps

module strobe_register (
    input  wire logic clk,
    input  wire logic reset,
    ctrl_if.sink      ctrl,
    output logic      read,
    output logic      ram_write,
    output logic      con_enable,
    output logic      pc_enable,
    output logic      ir_enable,
    output logic      y_enable,
    output logic      z_enable,
    output logic      mar_enable,
    output logic      mdr_enable,
    output logic      c_sign_extended_out,
    output logic      ba_out,
    output logic      gra,
    output logic      grb,
    output logic      grc,
    output logic      r_in,
    output logic      r_out,
    output logic      zlo_out,
    output logic      mdr_out,
    output logic      pc_out,
    output logic      pc_increment,
    output logic      y_clr,
    output logic      ir_clr,
    output logic      clr
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {read, ram_write, con_enable, pc_enable, ir_enable, y_enable,
             z_enable, mar_enable, mdr_enable, c_sign_extended_out, ba_out,
             gra, grb, grc, r_in, r_out, zlo_out, mdr_out, pc_out,
             pc_increment, y_clr, ir_clr} <= '0;
            clr <= 1'b1;  // preset so clr stays high through reset_step
        end else begin
            {read, ram_write, con_enable, pc_enable, ir_enable, y_enable,
             z_enable, mar_enable, mdr_enable, c_sign_extended_out, ba_out,
             gra, grb, grc, r_in, r_out, zlo_out, mdr_out, pc_out,
             pc_increment, y_clr, ir_clr} <=
            {ctrl.read, ctrl.ram_write, ctrl.con_enable, ctrl.pc_enable,
             ctrl.ir_enable, ctrl.y_enable, ctrl.z_enable, ctrl.mar_enable,
             ctrl.mdr_enable, ctrl.c_sign_extended_out, ctrl.ba_out,
             ctrl.gra, ctrl.grb, ctrl.grc, ctrl.r_in, ctrl.r_out,
             ctrl.zlo_out, ctrl.mdr_out, ctrl.pc_out, ctrl.pc_increment,
             ctrl.y_clr, ctrl.ir_clr};
            clr <= ctrl.hold_clr;
        end
    end

endmodule

`default_nettype wire

// File: logic/cu_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "cu_params.svh"

module cu_top
    import cu_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  con_ff,
    input  wire logic [`CU_WORD_W-1:0] ir,
    output logic                       read,
    output logic                       ram_write,
    output logic                       con_enable,
    output logic                       pc_enable,
    output logic                       ir_enable,
    output logic                       y_enable,
    output logic                       z_enable,
    output logic                       mar_enable,
    output logic                       mdr_enable,
    output logic                       c_sign_extended_out,
    output logic                       ba_out,
    output logic                       gra,
    output logic                       grb,
    output logic                       grc,
    output logic                       r_in,
    output logic                       r_out,
    output logic                       zlo_out,
    output logic                       mdr_out,
    output logic                       pc_out,
    output logic                       pc_increment,
    output logic                       y_clr,
    output logic                       ir_clr,
    output logic                       clr
);

    step_e  step;
    phase_e phase;

    ctrl_if ctrl_bus ();

    step_sequencer u_sequencer (
        .clk   (clk),
        .reset (reset),
        .ir    (ir),
        .step  (step),
        .phase (phase)
    );

    // combinational strobe table
    microstep_decoder u_decoder (
        .step   (step),
        .phase  (phase),
        .con_ff (con_ff),
        .ctrl   (ctrl_bus)
    );

    strobe_register u_strobes (
        .clk                 (clk),
        .reset               (reset),
        .ctrl                (ctrl_bus),
        .read                (read),
        .ram_write           (ram_write),
        .con_enable          (con_enable),
        .pc_enable           (pc_enable),
        .ir_enable           (ir_enable),
        .y_enable            (y_enable),
        .z_enable            (z_enable),
        .mar_enable          (mar_enable),
        .mdr_enable          (mdr_enable),
        .c_sign_extended_out (c_sign_extended_out),
        .ba_out              (ba_out),
        .gra                 (gra),
        .grb                 (grb),
        .grc                 (grc),
        .r_in                (r_in),
        .r_out               (r_out),
        .zlo_out             (zlo_out),
        .mdr_out             (mdr_out),
        .pc_out              (pc_out),
        .pc_increment        (pc_increment),
        .y_clr               (y_clr),
        .ir_clr              (ir_clr),
        .clr                 (clr)
    );

endmodule

`default_nettype wire

// File: bench/cu_checker.sv
`default_nettype none
`timescale 1ns/100ps

module cu_checker (
    input wire logic clk,
    input wire logic reset,
    input wire logic read, ram_write, con_enable, pc_enable, ir_enable, y_enable,
    input wire logic z_enable, mar_enable, mdr_enable, c_sign_extended_out, ba_out,
    input wire logic gra, grb, grc, r_in, r_out, zlo_out, mdr_out, pc_out,
    input wire logic pc_increment, y_clr, ir_clr, clr
);

    // one driver on the shared bus
    bus_single_driver: assert property (@(posedge clk) disable iff (reset)
        $onehot0({pc_out, zlo_out, mdr_out, c_sign_extended_out, r_out}))
        else $error("more than one bus driver enabled");

    no_load_during_write: assert property (@(posedge clk) disable iff (reset)
        !(r_in && ram_write))
        else $error("r_in and ram_write high together");

    ram_write_one_cycle: assert property (@(posedge clk) disable iff (reset)
        ram_write |=> !ram_write)
        else $error("ram_write held longer than one cycle");

    r_in_one_cycle: assert property (@(posedge clk) disable iff (reset)
        r_in |=> !r_in)
        else $error("r_in held longer than one cycle");

    // everything quiet while clr is up
    quiet_during_clr: assert property (@(posedge clk)
        clr |-> !(|{read, ram_write, con_enable, pc_enable, ir_enable, y_enable,
                    z_enable, mar_enable, mdr_enable, c_sign_extended_out, ba_out,
                    gra, grb, grc, r_in, r_out, zlo_out, mdr_out, pc_out,
                    pc_increment, y_clr, ir_clr}))
        else $error("strobe active while clr is high");

endmodule

bind cu_top cu_checker u_checker (.*);

`default_nettype wire

// File: bench/cu_tb.sv
`default_nettype none
`timescale 1ns/100ps

module cu_tb;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_ROWS   = 22;
    localparam int ROW_BUDGET = 20;  // cycles allowed per instruction

    logic        clk;
    logic        reset;
    logic        con_ff;
    logic [31:0] ir;
    logic read, ram_write, con_enable, pc_enable, ir_enable, y_enable, z_enable;
    logic mar_enable, mdr_enable, c_sign_extended_out, ba_out, gra, grb, grc;
    logic r_in, r_out, zlo_out, mdr_out, pc_out, pc_increment, y_clr, ir_clr, clr;
    logic [21:0] all_strobes;

    // instruction table
    string      row_name [NUM_ROWS];
    logic [4:0] row_op   [NUM_ROWS];
    logic       row_con  [NUM_ROWS];
    int         exp_len  [NUM_ROWS];
    int         exp_r_in [NUM_ROWS];
    int         exp_ram  [NUM_ROWS];
    int         exp_pc   [NUM_ROWS];
    int         exp_read [NUM_ROWS];
    int         exp_mar  [NUM_ROWS];

    logic [31:0] rand_state;
    int          error_count;
    int          pass_count;
    int          fail_count;

    cu_top DUT (.*);

    assign all_strobes = {read, ram_write, con_enable, pc_enable, ir_enable, y_enable,
                          z_enable, mar_enable, mdr_enable, c_sign_extended_out, ba_out,
                          gra, grb, grc, r_in, r_out, zlo_out, mdr_out, pc_out,
                          pc_increment, y_clr, ir_clr};

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #((NUM_ROWS * ROW_BUDGET + 50) * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles",
                 NUM_ROWS * ROW_BUDGET + 50);
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic add_row(input int idx, input string name, input logic [4:0] op,
                           input logic con, input int len, input int rin, input int ram,
                           input int pc, input int rd, input int mar);
        row_name[idx] = name;
        row_op[idx]   = op;
        row_con[idx]  = con;
        exp_len[idx]  = len;
        exp_r_in[idx] = rin;
        exp_ram[idx]  = ram;
        exp_pc[idx]   = pc;
        exp_read[idx] = rd;
        exp_mar[idx]  = mar;
    endtask

    task automatic compare_count(input string test, input string what, input int got,
                                 input int exp);
        assert (got == exp) else begin
            $display("Mismatch at %0d ns: %s %s is %0d, expected %0d",
                     $time, test, what, got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input string test, input int errs_before);
        if (error_count == errs_before) begin
            pass_count++;
            $display("%s: ok", test);
        end else begin
            fail_count++;
            $display("%s: FAIL", test);
        end
    endtask

    // entered at a falling edge where ir_clr is high, leaves at the next one
    task automatic run_row(input int idx);
        int cycles;
        int n_r_in;
        int n_ram;
        int n_pc;
        int n_read;
        int n_mar;
        int errs_before;
        cycles      = 0;
        n_r_in      = 0;
        n_ram       = 0;
        n_pc        = 0;
        n_read      = 0;
        n_mar       = 0;
        errs_before = error_count;
        rand_state  = lcg_next(rand_state);
        ir          = {row_op[idx], rand_state[30:4]};  // random register fields
        con_ff      = row_con[idx];
        do begin
            cycles++;
            n_r_in += int'(r_in);
            n_ram  += int'(ram_write);
            n_pc   += int'(pc_enable);
            n_read += int'(read);
            n_mar  += int'(mar_enable);
            @(negedge clk);
        end while (!ir_clr);
        compare_count(row_name[idx], "length", cycles, exp_len[idx]);
        compare_count(row_name[idx], "r_in", n_r_in, exp_r_in[idx]);
        compare_count(row_name[idx], "ram_write", n_ram, exp_ram[idx]);
        compare_count(row_name[idx], "pc_enable", n_pc, exp_pc[idx]);
        compare_count(row_name[idx], "read", n_read, exp_read[idx]);
        compare_count(row_name[idx], "mar_enable", n_mar, exp_mar[idx]);
        report_test(row_name[idx], errs_before);
    endtask

    initial begin : main
        int errs_before;
        reset       = 1'b1;
        con_ff      = 1'b0;
        ir          = '0;
        rand_state  = 32'd6;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;

        //          name       op        con len rin ram pc rd mar
        add_row(0,  "ld",      5'b00000, 0, 16, 1, 0, 1, 2, 2);
        add_row(1,  "ldi",     5'b00001, 0, 12, 1, 0, 1, 1, 1);
        add_row(2,  "st",      5'b00010, 0, 16, 0, 1, 1, 1, 2);
        add_row(3,  "add",     5'b00011, 0, 12, 1, 0, 1, 1, 1);
        add_row(4,  "sub",     5'b00100, 0, 12, 1, 0, 1, 1, 1);
        add_row(5,  "shr",     5'b00101, 0, 12, 1, 0, 1, 1, 1);
        add_row(6,  "shra",    5'b00110, 0, 12, 1, 0, 1, 1, 1);
        add_row(7,  "shl",     5'b00111, 0, 12, 1, 0, 1, 1, 1);
        add_row(8,  "ror",     5'b01000, 0, 12, 1, 0, 1, 1, 1);
        add_row(9,  "rol",     5'b01001, 0, 12, 1, 0, 1, 1, 1);
        add_row(10, "and",     5'b01010, 0, 12, 1, 0, 1, 1, 1);
        add_row(11, "or",      5'b01011, 0, 12, 1, 0, 1, 1, 1);
        add_row(12, "addi",    5'b01100, 0, 12, 1, 0, 1, 1, 1);
        add_row(13, "andi",    5'b01101, 0, 12, 1, 0, 1, 1, 1);
        add_row(14, "ori",     5'b01110, 0, 12, 1, 0, 1, 1, 1);
        add_row(15, "neg",     5'b10001, 0, 10, 1, 0, 1, 1, 1);
        add_row(16, "not",     5'b10010, 0, 10, 1, 0, 1, 1, 1);
        add_row(17, "br_taken", 5'b10011, 1, 14, 0, 0, 2, 1, 1);
        add_row(18, "br_not",  5'b10011, 0, 14, 0, 0, 1, 1, 1);
        add_row(19, "nop",     5'b11010, 0, 8,  0, 0, 1, 1, 1);
        add_row(20, "mul",     5'b01111, 0, 8,  0, 0, 1, 1, 1);  // dropped
        add_row(21, "undef",   5'b11111, 1, 8,  0, 0, 1, 1, 1);

        // reset held for 3 cycles
        errs_before = error_count;
        repeat (3) @(negedge clk);
        compare_count("reset", "strobes", int'(all_strobes), 0);
        compare_count("reset", "clr", int'(clr), 1);
        reset = 1'b0;
        @(negedge clk);
        compare_count("reset", "clr after release", int'(clr), 1);
        while (!ir_clr) @(negedge clk);
        compare_count("reset", "clr at first fetch", int'(clr), 0);
        report_test("reset", errs_before);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/isa_pkg.sv
logic/cu_pkg.sv
logic/ctrl_if.sv
logic/step_sequencer.sv
logic/microstep_decoder.sv
logic/strobe_register.sv
logic/cu_top.sv
bench/cu_checker.sv
bench/cu_tb.sv

// File: Makefile
TOP = cu_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
